/* files.f */
+incdir+hw
hw/ucode_pkg.sv
hw/crom.sv
hw/skip_mux.sv
hw/ucall_stack.sv
hw/useq.sv
hw/microcontroller.sv
verification/microcontroller_assertions.sv
verification/microcontroller_tb.sv

/* hw/crom.sv */
////////////////////////////////////////
// Writable control store
// Sync write port, async read, field split
////////////////////////////////////////
`timescale 1ns/10ps
`include "ucode_settings.svh"

module crom
   import ucode_pkg::*;
(
   input  logic                     clk,
   // Load port
   input  logic                     crom_wr,
   input  logic [7:0]               crom_wr_addr,
   input  logic [`CROM_WIDTH-1:0]   crom_wr_data,
   // Current microaddress
   input  logic [`UADDR_WIDTH-1:0]  upc,
   // Decoded microword fields
   output logic [`UADDR_WIDTH-1:0]  j,
   output seq_op_t                  op,
   output skip_bank_t               skip_bank,
   output logic [2:0]               skip_sel
);

   // Microword storage
   logic [`CROM_WIDTH-1:0] store [`CROM_DEPTH];

   // Word at the current microaddress
   logic [`CROM_WIDTH-1:0] uword;

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   // New word is visible to a read in the next cycle
   always_ff @(posedge clk)
   begin
      if (crom_wr)
      begin
         store[crom_wr_addr] <= crom_wr_data;
      end
   end

   ////////////////////////////////////////
   // Read and field split
   ////////////////////////////////////////

   // Only the low 8 address bits reach the array
   assign uword = store[upc[7:0]];

   // Next address base
   assign j = uword[`CROM_J_LSB +: `UADDR_WIDTH];

   // Sequencer operation
   assign op = seq_op_t'(uword[`CROM_OP_LSB +: 2]);

   // Skip condition bank and bit position
   assign skip_bank = skip_bank_t'(uword[`CROM_BANK_LSB +: 2]);
   assign skip_sel  = uword[`CROM_SEL_LSB +: 3];

endmodule

/* hw/microcontroller.sv */
////////////////////////////////////////
// Microcontroller top level
// Store, skip mux, stack and sequencer
////////////////////////////////////////
`timescale 1ns/10ps
`include "ucode_settings.svh"

module microcontroller
   import ucode_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     run,
   // Control store load port
   input  logic                     crom_wr,
   input  logic [7:0]               crom_wr_addr,
   input  logic [`CROM_WIDTH-1:0]   crom_wr_data,
   // Condition banks
   input  logic [0:7]               skip_40,
   input  logic [0:7]               skip_20,
   input  logic [0:7]               skip_10,
   // Dispatch value
   input  logic [7:0]               disp,
   output logic [`UADDR_WIDTH-1:0]  upc,
   output logic                     stack_err
);

   // Microword fields
   logic [`UADDR_WIDTH-1:0] j;
   seq_op_t                 op;
   skip_bank_t              skip_bank;
   logic [2:0]              skip_sel;

   // Skip term and stack traffic
   logic [`UADDR_WIDTH-1:0] skip_addr;
   logic [`UADDR_WIDTH-1:0] top;
   logic [`UADDR_WIDTH-1:0] ret_addr;
   logic                    push;
   logic                    pop;

   // Control store
   crom u_crom
   (
      .clk          (clk),
      .crom_wr      (crom_wr),
      .crom_wr_addr (crom_wr_addr),
      .crom_wr_data (crom_wr_data),
      .upc          (upc),
      .j            (j),
      .op           (op),
      .skip_bank    (skip_bank),
      .skip_sel     (skip_sel)
   );

   // Skip condition select
   skip_mux u_skip
   (
      .skip_bank (skip_bank),
      .skip_sel  (skip_sel),
      .skip_40   (skip_40),
      .skip_20   (skip_20),
      .skip_10   (skip_10),
      .skip_addr (skip_addr)
   );

   // Return stack
   ucall_stack u_stack
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .pop       (pop),
      .ret_addr  (ret_addr),
      .top       (top),
      .stack_err (stack_err)
   );

   // Sequencer
   useq u_useq
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .j         (j),
      .op        (op),
      .skip_addr (skip_addr),
      .disp      (disp),
      .top       (top),
      .push      (push),
      .pop       (pop),
      .ret_addr  (ret_addr),
      .upc       (upc)
   );

endmodule

/* hw/skip_mux.sv */
////////////////////////////////////////
// Skip condition selector
// One bit out of three banks of eight
////////////////////////////////////////
`timescale 1ns/10ps
`include "ucode_settings.svh"

module skip_mux
   import ucode_pkg::*;
(
   // Bank and bit select from the microword
   input  skip_bank_t               skip_bank,
   input  logic [2:0]               skip_sel,
   // Condition banks, bit 0 on the left
   input  logic [0:7]               skip_40,
   input  logic [0:7]               skip_20,
   input  logic [0:7]               skip_10,
   // Address term ORed into the jump target
   output logic [`UADDR_WIDTH-1:0]  skip_addr
);

   // Bank picked by the microword
   logic [0:7] bank;

   // Selected condition bit
   logic       sk;

   ////////////////////////////////////////
   // Bank select
   ////////////////////////////////////////

   // Port names shadow the enum literals here, so scope them
   always_comb
   begin
      bank = 8'h00;
      case (skip_bank)
         ucode_pkg::skip_40:
            bank = skip_40;
         ucode_pkg::skip_20:
            bank = skip_20;
         ucode_pkg::skip_10:
            bank = skip_10;
         default:
            // skip_none leaves every bit clear
            bank = 8'h00;
      endcase
   end

   // Bit within the bank, counted from the left
   assign sk = bank[skip_sel];

   // Skip lands in the low microaddress bit
   assign skip_addr = sk ? `UADDR_WIDTH'(1) : '0;

endmodule

/* hw/ucall_stack.sv */
////////////////////////////////////////
// Micro-call return address stack
// LIFO with sticky overflow/underflow flag
////////////////////////////////////////
`timescale 1ns/10ps
`include "ucode_settings.svh"

module ucall_stack
(
   input  logic                     clk,
   input  logic                     rst_n,
   // Stack controls from the sequencer
   input  logic                     push,
   input  logic                     pop,
   input  logic [`UADDR_WIDTH-1:0]  ret_addr,
   // Entry that the next pop returns
   output logic [`UADDR_WIDTH-1:0]  top,
   // Sticky error, cleared by reset only
   output logic                     stack_err
);

   // Pointer counts 0 to STACK_DEPTH entries
   localparam int PTR_W = $clog2(`STACK_DEPTH + 1);
   localparam int IDX_W = $clog2(`STACK_DEPTH);

   // Return address entries
   logic [`UADDR_WIDTH-1:0] entries [`STACK_DEPTH];

   // Number of valid entries
   logic [PTR_W-1:0]        ptr;
   logic [IDX_W-1:0]        top_idx;
   logic                    full;
   logic                    empty;

   ////////////////////////////////////////
   // Status and top of stack
   ////////////////////////////////////////

   assign full    = (ptr == PTR_W'(`STACK_DEPTH));
   assign empty   = (ptr == '0);
   assign top_idx = IDX_W'(ptr - 1'b1);

   // Underflow returns address 0
   assign top = empty ? '0 : entries[top_idx];

   ////////////////////////////////////////
   // Pointer and error flag
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ptr       <= '0;
         stack_err <= 1'b0;
      end
      else if (push)
      begin
         // Overflow drops the entry
         if (full)
            stack_err <= 1'b1;
         else
            ptr <= ptr + 1'b1;
      end
      else if (pop)
      begin
         // Underflow leaves pointer at zero
         if (empty)
            stack_err <= 1'b1;
         else
            ptr <= ptr - 1'b1;
      end
   end

   // Entry write, only when there is room
   always_ff @(posedge clk)
   begin
      if (push && !full)
      begin
         entries[ptr[IDX_W-1:0]] <= ret_addr;
      end
   end

endmodule

/* hw/ucode_pkg.sv */
////////////////////////////////////////
// Microcontroller shared types
// Sequencer operations and skip banks
////////////////////////////////////////
package ucode_pkg;

   ////////////////////////////////////////
   // Sequencer operation field
   ////////////////////////////////////////

   // How the next microaddress is formed
   typedef enum logic [1:0]
   {
      // J field ORed with the skip bit
      op_jump     = 2'b00,
      // Same as jump, return address pushed
      op_call     = 2'b01,
      // Address comes off the return stack
      op_return   = 2'b10,
      // J field ORed with external dispatch
      op_dispatch = 2'b11
   } seq_op_t;

   ////////////////////////////////////////
   // Skip bank field
   ////////////////////////////////////////

   // Which condition bank feeds the skip bit
   typedef enum logic [1:0]
   {
      // No skip, address bit stays clear
      skip_none = 2'b00,
      skip_40   = 2'b01,
      skip_20   = 2'b10,
      skip_10   = 2'b11
   } skip_bank_t;

endpackage

/* hw/ucode_settings.svh */
////////////////////////////////////////
// Microcontroller sizing macros
// Address, control store, microword and
// return stack dimensions
////////////////////////////////////////
`ifndef UCODE_SETTINGS_SVH
`define UCODE_SETTINGS_SVH

// Microaddress width
`define UADDR_WIDTH 12

// Control store depth, indexed by the low 8 address bits
`define CROM_DEPTH 256

// Microword width: J(12) op(2) skip bank(2) skip select(3)
`define CROM_WIDTH 19

// Field positions inside the microword, LSB of each field
`define CROM_J_LSB 7
`define CROM_OP_LSB 5
`define CROM_BANK_LSB 3
`define CROM_SEL_LSB 0

// Return address entries
`define STACK_DEPTH 4

`endif

/* hw/useq.sv */
////////////////////////////////////////
// Microsequencer next-address logic
// Picks next address, holds micro PC
////////////////////////////////////////
`timescale 1ns/10ps
`include "ucode_settings.svh"

module useq
   import ucode_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   // Advance enable, the only stall
   input  logic                     run,
   // Microword fields
   input  logic [`UADDR_WIDTH-1:0]  j,
   input  seq_op_t                  op,
   // Skip term from the skip mux
   input  logic [`UADDR_WIDTH-1:0]  skip_addr,
   // External dispatch value
   input  logic [7:0]               disp,
   // Return address from the stack
   input  logic [`UADDR_WIDTH-1:0]  top,
   // Stack controls
   output logic                     push,
   output logic                     pop,
   output logic [`UADDR_WIDTH-1:0]  ret_addr,
   // Micro program counter
   output logic [`UADDR_WIDTH-1:0]  upc
);

   // Chosen next microaddress
   logic [`UADDR_WIDTH-1:0] next_addr;

   // Dispatch value widened to an address
   logic [`UADDR_WIDTH-1:0] disp_addr;

   assign disp_addr = {{(`UADDR_WIDTH-8){1'b0}}, disp};

   ////////////////////////////////////////
   // Next address select
   ////////////////////////////////////////

   always_comb
   begin
      // Jump is the fallback
      next_addr = j | skip_addr;
      case (op)
         op_jump:
            next_addr = j | skip_addr;
         // Call targets like a jump
         op_call:
            next_addr = j | skip_addr;
         // Popped address
         op_return:
            next_addr = top;
         // Multiway branch on external value
         op_dispatch:
            next_addr = j | disp_addr;
         default:
            next_addr = j | skip_addr;
      endcase
   end

   ////////////////////////////////////////
   // Stack controls
   ////////////////////////////////////////

   // Pointer moves at the same edge upc loads
   assign push = run && (op == op_call);
   assign pop  = run && (op == op_return);

   // Call returns to the word after itself
   assign ret_addr = upc + 1'b1;

   ////////////////////////////////////////
   // Micro program counter
   ////////////////////////////////////////

   // One microword per cycle while running
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         upc <= '0;
      end
      else if (run)
      begin
         upc <= next_addr;
      end
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the microcontroller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f \
    --top-module microcontroller_tb -o microcontroller_sim
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator build failed"
    exit 1
fi

./obj_dir/microcontroller_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "ERROR: simulation exited with status $sim_status"
    exit 1
fi

# Verdict comes from the log
if grep -q "Everything OK" "$LOG"; then
    echo "RESULT: pass"
    exit 0
fi
echo "RESULT: fail"
exit 1

/* verification/microcontroller_assertions.sv */
////////////////////////////////////////
// Sequencer and return stack assertions
////////////////////////////////////////
`timescale 1ns/10ps
`include "ucode_settings.svh"

module microcontroller_assertions
#(
   // High for the copy bound into the sequencer
   parameter bit SEQ_SIDE = 1'b1
)
(
   input logic                    clk,
   input logic                    rst_n,
   input logic                    run,
   input logic                    push,
   input logic                    pop,
   input logic [`UADDR_WIDTH-1:0] upc,
   input logic                    stack_err
);

   generate
      if (SEQ_SIDE)
      begin : g_seq
         // A microword never calls and returns at once
         a_push_pop: assert property (@(posedge clk) disable iff (!rst_n) !(push && pop))
            else $error("push and pop high in the same cycle");

         // Stall holds the micro PC
         a_upc_hold: assert property (@(posedge clk) disable iff (!rst_n) !run |=> $stable(upc))
            else $error("upc moved while run was low");
      end
      else
      begin : g_stack
         // Sticky error only clears on reset
         a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(stack_err))
            else $error("stack_err fell without reset");
      end
   endgenerate

endmodule

// Sequencer side watches the stack controls and the micro PC
bind useq microcontroller_assertions #(.SEQ_SIDE(1'b1)) u_seq_sva
(
   .clk       (clk),
   .rst_n     (rst_n),
   .run       (run),
   .push      (push),
   .pop       (pop),
   .upc       (upc),
   .stack_err (1'b0)
);

// Stack side watches the sticky error
bind ucall_stack microcontroller_assertions #(.SEQ_SIDE(1'b0)) u_stack_sva
(
   .clk       (clk),
   .rst_n     (rst_n),
   .run       (1'b1),
   .push      (push),
   .pop       (pop),
   .upc       ({`UADDR_WIDTH{1'b0}}),
   .stack_err (stack_err)
);

/* verification/microcontroller_tb.sv */
////////////////////////////////////////
// Microcontroller testbench
// Loads microcode, steps a table, checks upc
////////////////////////////////////////
`timescale 1ns/10ps
`include "ucode_settings.svh"

module microcontroller_tb
   import ucode_pkg::*;
();

   localparam logic [31:0] LFSR_SEED     = 32'hafaa;
   localparam int          RESET_TIMEOUT = 10;
   localparam int          NUM_STEPS     = 15;

   // One row per phase
   // Fill bits pick LFSR data for 40, 20, 10 and disp
   typedef struct packed
   {
      logic       run;
      logic [3:0] fill;
      logic [0:7] s40;
      logic [0:7] s20;
      logic [0:7] s10;
      logic [7:0] disp;
      logic [7:0] cycles;
      logic       exp_err;
   } step_t;

   step_t steps [NUM_STEPS] = '{
      '{1'b1, 4'b0000, 8'hff, 8'hff, 8'hff, 8'h00, 8'd1,  1'b0},
      '{1'b1, 4'b0000, 8'hff, 8'hff, 8'hff, 8'h00, 8'd24, 1'b0},
      '{1'b1, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h20, 8'd1,  1'b0},
      '{1'b1, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 8'd24, 1'b0},
      '{1'b1, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h20, 8'd1,  1'b0},
      '{1'b1, 4'b1110, 8'h00, 8'h00, 8'h00, 8'h00, 8'd24, 1'b0},
      '{1'b1, 4'b0001, 8'h00, 8'h00, 8'h00, 8'h00, 8'd16, 1'b0},
      '{1'b0, 4'b1111, 8'h00, 8'h00, 8'h00, 8'h00, 8'd4,  1'b0},
      '{1'b1, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h60, 8'd1,  1'b0},
      '{1'b1, 4'b0000, 8'hff, 8'hff, 8'hff, 8'h00, 8'd9,  1'b0},
      '{1'b1, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 8'd4,  1'b0},
      '{1'b1, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 8'd1,  1'b1},
      '{1'b1, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 8'd5,  1'b1},
      '{1'b1, 4'b1110, 8'h00, 8'h00, 8'h00, 8'h00, 8'd6,  1'b1},
      '{1'b0, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 8'd3,  1'b1}
   };

   string step_names [NUM_STEPS] = '{
      "skip_none", "skip_ones", "hub_to_chain", "skip_zeros", "hub_to_chain_again",
      "skip_random", "dispatch_random", "run_low_hold", "resume_dispatch",
      "call_return", "calls_to_full", "fifth_call", "unwind_to_empty", "err_sticky",
      "err_run_low"
   };

   // DUT connections
   logic                    clk;
   logic                    rst_n;
   logic                    run;
   logic                    crom_wr;
   logic [7:0]              crom_wr_addr;
   logic [`CROM_WIDTH-1:0]  crom_wr_data;
   logic [0:7]              skip_40;
   logic [0:7]              skip_20;
   logic [0:7]              skip_10;
   logic [7:0]              disp;
   logic [`UADDR_WIDTH-1:0] upc;
   logic                    stack_err;

   // Reference model state
   logic [`CROM_WIDTH-1:0]  image [`CROM_DEPTH];
   logic [`UADDR_WIDTH-1:0] m_upc;
   logic [`UADDR_WIDTH-1:0] m_stack [`STACK_DEPTH];
   int                      m_depth;
   logic [31:0]             lfsr;

   microcontroller DUT
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .run          (run),
      .crom_wr      (crom_wr),
      .crom_wr_addr (crom_wr_addr),
      .crom_wr_data (crom_wr_data),
      .skip_40      (skip_40),
      .skip_20      (skip_20),
      .skip_10      (skip_10),
      .disp         (disp),
      .upc          (upc),
      .stack_err    (stack_err)
   );

   // 100 ns clock
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset held for 3 cycles
   initial
   begin
      rst_n = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_addr(input string name, input logic [`UADDR_WIDTH-1:0] exp,
                             input logic [`UADDR_WIDTH-1:0] act);
      if (act !== exp)
         stop_with_failure($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_with_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function logic [7:0] rand_value(input int nbits);
      logic [7:0] v;
      v = 8'h00;
      for (int k = 0; k < nbits; k++)
         v = {v[6:0], lfsr_bit()};
      return v;
   endfunction

   function automatic logic [`CROM_WIDTH-1:0] make_word(input logic [11:0] jv,
      input seq_op_t o, input skip_bank_t b, input logic [2:0] s);
      return {jv, o, b, s};
   endfunction

   // Microprogram image
   task automatic build_image();
      // Default words return to the hub
      // Upper J bits tag the address
      for (int a = 0; a < `CROM_DEPTH; a++)
         image[a] = make_word({4'(a[7:4] ^ a[3:0]), 8'h50}, op_jump, ucode_pkg::skip_none,
                              3'(a));
      image[0] = make_word(12'h020, op_jump, ucode_pkg::skip_none, 3'd5);
      // Skip chain with identical words on both landing addresses of a pair
      for (int k = 0; k < 24; k++)
      begin
         image[32 + 2 * k] = make_word(12'(34 + 2 * k), op_jump, skip_bank_t'(2'(k / 8 + 1)),
                                       3'(k % 8));
         image[33 + 2 * k] = image[32 + 2 * k];
      end
      // Dispatch hub
      image[8'h50] = make_word(12'h100, op_dispatch, ucode_pkg::skip_none, 3'd0);
      image[8'h51] = image[8'h50];
      // Four nested calls that unwind in reverse order
      for (int i = 0; i < 4; i++)
         image[8'h60 + 4 * i] = make_word(12'(8'h64 + 4 * i), op_call, ucode_pkg::skip_none,
                                          3'd0);
      for (int i = 1; i < 4; i++)
         image[8'h61 + 4 * i] = make_word(12'h000, op_return, ucode_pkg::skip_none, 3'd0);
      image[8'h70] = make_word(12'h000, op_return, ucode_pkg::skip_none, 3'd0);
      image[8'h61] = make_word(12'h074, op_jump, ucode_pkg::skip_none, 3'd0);
      // Five nested calls overflow the stack
      // Unwinding one return too far lands on address 0
      for (int i = 0; i < 5; i++)
      begin
         image[8'h74 + 2 * i] = make_word(12'(8'h76 + 2 * i), op_call, ucode_pkg::skip_none,
                                          3'd0);
         image[8'h75 + 2 * i] = make_word(12'h000, op_return, ucode_pkg::skip_none, 3'd0);
      end
      image[8'h7e] = make_word(12'h000, op_return, ucode_pkg::skip_none, 3'd0);
   endtask

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   task automatic model_step(input logic [0:7] b40, input logic [0:7] b20,
                             input logic [0:7] b10, input logic [7:0] d);
      logic [`CROM_WIDTH-1:0]  w;
      logic [`UADDR_WIDTH-1:0] jf;
      logic [1:0]              opf;
      logic [1:0]              bankf;
      logic [2:0]              sel;
      logic                    sk;
      w = image[m_upc[7:0]];
      // Same field order as make_word
      {jf, opf, bankf, sel} = w;
      case (skip_bank_t'(bankf))
         ucode_pkg::skip_40:
            sk = b40[sel];
         ucode_pkg::skip_20:
            sk = b20[sel];
         ucode_pkg::skip_10:
            sk = b10[sel];
         default:
            sk = 1'b0;
      endcase
      case (seq_op_t'(opf))
         op_call:
         begin
            // Full stack drops the return address
            if (m_depth < `STACK_DEPTH)
            begin
               m_stack[m_depth] = m_upc + 12'd1;
               m_depth++;
            end
            m_upc = jf | {11'b0, sk};
         end
         op_return:
         begin
            if (m_depth == 0)
               m_upc = '0;
            else
            begin
               m_depth--;
               m_upc = m_stack[m_depth];
            end
         end
         op_dispatch:
            m_upc = jf | {4'b0, d};
         default:
            m_upc = jf | {11'b0, sk};
      endcase
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (rst_n !== 1'b1)
      begin
         if (n == RESET_TIMEOUT)
            stop_with_failure("reset was not released in time");
         else
         begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      run          = 1'b0;
      crom_wr      = 1'b0;
      crom_wr_addr = 8'h00;
      crom_wr_data = '0;
      skip_40      = 8'h00;
      skip_20      = 8'h00;
      skip_10      = 8'h00;
      disp         = 8'h00;
      lfsr         = LFSR_SEED;
      m_upc        = '0;
      m_depth      = 0;
      build_image();
      wait_reset_release();
      check_addr("reset_state", '0, upc);
      check_flag("reset_state", 1'b0, stack_err);
      // Load the control store while upc stays put
      for (int a = 0; a < `CROM_DEPTH; a++)
      begin
         crom_wr      = 1'b1;
         crom_wr_addr = 8'(a);
         crom_wr_data = image[a];
         @(negedge clk);
         check_addr("crom_load", '0, upc);
      end
      crom_wr = 1'b0;
      // Step table
      for (int i = 0; i < NUM_STEPS; i++)
      begin
         for (int c = 0; c < int'(steps[i].cycles); c++)
         begin
            run     = steps[i].run;
            skip_40 = steps[i].fill[3] ? rand_value(8) : steps[i].s40;
            skip_20 = steps[i].fill[2] ? rand_value(8) : steps[i].s20;
            skip_10 = steps[i].fill[1] ? rand_value(8) : steps[i].s10;
            // Random dispatch kept in the upper half of the store
            disp    = steps[i].fill[0] ? (8'h80 | rand_value(7)) : steps[i].disp;
            if (run)
               model_step(skip_40, skip_20, skip_10, disp);
            @(negedge clk);
            check_addr(step_names[i], m_upc, upc);
            check_flag(step_names[i], steps[i].exp_err, stack_err);
         end
      end
      $display("Everything OK");
      $finish;
   end

endmodule
